// File: source/xy_route_consts.svh
// xy route selector constants
// mesh geometry, field widths and output port indices
// shared by the package and every routing block

`ifndef XY_ROUTE_CONSTS_SVH
`define XY_ROUTE_CONSTS_SVH

// mesh columns and rows
`define XY_NUM_X 4
`define XY_NUM_Y 4

// bits per coordinate axis
`define XY_COORD_W 2

// one bit per node, node index = x * rows + y
`define XY_MASK_W 16

// router outputs and width of the replication count
`define XY_NUM_ROUTES 5
`define XY_REP_W 3

// output port indices
`define XY_PORT_EJECT 0
`define XY_PORT_SOUTH 1
`define XY_PORT_WEST 2
`define XY_PORT_NORTH 3
`define XY_PORT_EAST 4

// flit payload
`define XY_PAYLOAD_W 32

`endif

// File: source/xy_route_pkg.sv
// xy route selector types
// coordinate pair, destination word with its two views,
// flit header and full flit

`include "xy_route_consts.svh"

package xy_route_pkg;

  // router position in the mesh, x in the upper bits
  typedef struct packed {
    logic [`XY_COORD_W-1:0] x;
    logic [`XY_COORD_W-1:0] y;
  } xy_coord_t;

  // unicast view of the destination word
  // coordinate sits in the low bits, rest is unused
  typedef struct packed {
    logic [`XY_MASK_W-2*`XY_COORD_W-1:0] rsvd;
    xy_coord_t                            coord;
  } xy_pos_t;

  // one destination word, decoded by the mcast flag
  // pos for unicast, mask for multicast
  typedef union packed {
    xy_pos_t                pos;
    logic [`XY_MASK_W-1:0] mask;
  } xy_dst_u;

  // 18 bit header
  typedef struct packed {
    logic    mcast;
    logic    last;
    xy_dst_u dst;
  } xy_hdr_t;

  // header plus payload, 50 bits
  typedef struct packed {
    xy_hdr_t                   hdr;
    logic [`XY_PAYLOAD_W-1:0] payload;
  } xy_flit_t;

endpackage

// File: source/xy_unicast_decoder.sv
// unicast xy decoder
// dimension ordered routing, x first then y
// compares destination with own position, one-hot route out

`timescale 1ns/100ps

`include "xy_route_consts.svh"

module xy_unicast_decoder (
  input  xy_route_pkg::xy_coord_t    dst_i,
  input  xy_route_pkg::xy_coord_t    xy_id_i,
  output logic [`XY_NUM_ROUTES-1:0] route_o
);

  logic same_x;
  logic same_y;

  // axis matches
  assign same_x = (dst_i.x == xy_id_i.x);
  assign same_y = (dst_i.y == xy_id_i.y);

  // exactly one bit set for every destination
  always_comb begin
    route_o = '0;
    if (same_x && same_y) begin
      // arrived, hand to local endpoint
      route_o[`XY_PORT_EJECT] = 1'b1;
    end else if (same_x) begin
      // column done, resolve y
      if (dst_i.y < xy_id_i.y) begin
        route_o[`XY_PORT_SOUTH] = 1'b1;
      end else begin
        route_o[`XY_PORT_NORTH] = 1'b1;
      end
    end else begin
      // x still open, y ignored here
      if (dst_i.x < xy_id_i.x) begin
        route_o[`XY_PORT_WEST] = 1'b1;
      end else begin
        route_o[`XY_PORT_EAST] = 1'b1;
      end
    end
  end

endmodule

// File: source/mcast_port_select.sv
// multicast port selection
// scans the destination bitmask and flags every output
// that leads towards at least one marked node, x first then y
// also counts the flagged outputs for replication

`timescale 1ns/100ps

`include "xy_route_consts.svh"

module mcast_port_select (
  input  logic [`XY_MASK_W-1:0]     mask_i,
  input  xy_route_pkg::xy_coord_t    xy_id_i,
  output logic [`XY_NUM_ROUTES-1:0] route_o,
  output logic [`XY_REP_W-1:0]      rep_coeff_o
);

  int own_x;
  int own_y;

  // own position as plain integers for the scan
  assign own_x = int'(xy_id_i.x);
  assign own_y = int'(xy_id_i.y);

  // direction per marked node
  always_comb begin
    route_o = '0;
    for (int x = 0; x < `XY_NUM_X; x++) begin
      for (int y = 0; y < `XY_NUM_Y; y++) begin
        if (mask_i[x*`XY_NUM_Y+y]) begin
          if (x > own_x) begin
            route_o[`XY_PORT_EAST] = 1'b1;
          end else if (x < own_x) begin
            route_o[`XY_PORT_WEST] = 1'b1;
          end else if (y > own_y) begin
            // own column, above
            route_o[`XY_PORT_NORTH] = 1'b1;
          end else if (y < own_y) begin
            // own column, below
            route_o[`XY_PORT_SOUTH] = 1'b1;
          end else begin
            // own node bit
            route_o[`XY_PORT_EJECT] = 1'b1;
          end
        end
      end
    end
  end

  // popcount of the route vector
  // at most 5, fits the count width
  always_comb begin
    rep_coeff_o = '0;
    for (int r = 0; r < `XY_NUM_ROUTES; r++) begin
      rep_coeff_o = rep_coeff_o + `XY_REP_W'(route_o[r]);
    end
  end

endmodule

// File: source/mcast_mask_split.sv
// multicast mask splitter
// makes one copy of the flit per output and trims the
// bitmask to the nodes reached through that output
// unicast flits go out unchanged on every output

`timescale 1ns/100ps

`include "xy_route_consts.svh"

module mcast_mask_split (
  input  xy_route_pkg::xy_flit_t                        flit_i,
  input  xy_route_pkg::xy_coord_t                       xy_id_i,
  output xy_route_pkg::xy_flit_t [`XY_NUM_ROUTES-1:0]  flit_o
);

  // constant masks per column and row, plus running unions
  logic [`XY_NUM_X-1:0][`XY_MASK_W-1:0] col_mask;
  logic [`XY_NUM_X-1:0][`XY_MASK_W-1:0] col_le;
  logic [`XY_NUM_Y-1:0][`XY_MASK_W-1:0] row_mask;
  logic [`XY_NUM_Y-1:0][`XY_MASK_W-1:0] row_le;

  logic [`XY_MASK_W-1:0] mask_in;
  logic [`XY_MASK_W-1:0] own_col;
  logic [`XY_NUM_ROUTES-1:0][`XY_MASK_W-1:0] route_mask;

  // column x owns one contiguous group of rows
  for (genvar x = 0; x < `XY_NUM_X; x++) begin : gen_col
    assign col_mask[x] = `XY_MASK_W'({`XY_NUM_Y{1'b1}}) << (x * `XY_NUM_Y);
    if (x == 0) begin : gen_first
      assign col_le[x] = col_mask[x];
    end else begin : gen_next
      // columns 0 to x
      assign col_le[x] = col_le[x-1] | col_mask[x];
    end
  end

  // row y repeats the same bit in every column group
  for (genvar y = 0; y < `XY_NUM_Y; y++) begin : gen_row
    assign row_mask[y] = {`XY_NUM_X{`XY_NUM_Y'(1 << y)}};
    if (y == 0) begin : gen_first
      assign row_le[y] = row_mask[y];
    end else begin : gen_next
      // rows 0 to y
      assign row_le[y] = row_le[y-1] | row_mask[y];
    end
  end

  assign mask_in = flit_i.hdr.dst.mask;
  assign own_col = col_mask[xy_id_i.x];

  // per output restriction
  assign route_mask[`XY_PORT_EJECT] = mask_in;
  assign route_mask[`XY_PORT_EAST]  = mask_in & ~col_le[xy_id_i.x];
  assign route_mask[`XY_PORT_WEST]  = mask_in & col_le[xy_id_i.x] & ~own_col;
  assign route_mask[`XY_PORT_NORTH] = mask_in & own_col & ~row_le[xy_id_i.y];
  assign route_mask[`XY_PORT_SOUTH] = mask_in & own_col & row_le[xy_id_i.y]
                                    & ~row_mask[xy_id_i.y];

  // payload and flags copied as is
  always_comb begin
    for (int r = 0; r < `XY_NUM_ROUTES; r++) begin
      flit_o[r] = flit_i;
      if (flit_i.hdr.mcast) begin
        flit_o[r].hdr.dst.mask = route_mask[r];
      end
    end
  end

endmodule

// File: source/route_lock_ctrl.sv
// route lock control
// picks the unicast or multicast route, zero without valid,
// and holds the head flit route until the last flit is taken
// replication count passes through, never held

`timescale 1ns/100ps

`include "xy_route_consts.svh"

module route_lock_ctrl (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      valid_i,
  input  logic                      ready_i,
  input  logic                      mcast_i,
  input  logic                      last_i,
  input  logic [`XY_NUM_ROUTES-1:0] ucast_route_i,
  input  logic [`XY_NUM_ROUTES-1:0] mcast_route_i,
  input  logic [`XY_REP_W-1:0]      mcast_rep_i,
  output logic [`XY_NUM_ROUTES-1:0] route_sel_o,
  output logic [`XY_REP_W-1:0]      rep_coeff_o
);

  logic                      accept;
  logic                      locked_q;
  logic [`XY_NUM_ROUTES-1:0] route_res;
  logic [`XY_NUM_ROUTES-1:0] route_q;

  // handshake completes this cycle
  assign accept = valid_i & ready_i;

  // live route of the current flit
  always_comb begin
    if (!valid_i) begin
      route_res = '0;
    end else if (mcast_i) begin
      route_res = mcast_route_i;
    end else begin
      route_res = ucast_route_i;
    end
  end

  // lock state, only moves on an accepted flit
  // non-last locks, last releases
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      locked_q <= 1'b0;
      route_q  <= '0;
    end else if (accept) begin
      locked_q <= ~last_i;
      // capture only on the head of a multi-flit packet
      if (!locked_q && !last_i) begin
        route_q <= route_res;
      end
    end
  end

  // held route wins while locked, even with valid low
  assign route_sel_o = locked_q ? route_q : route_res;

  // count of the current flit only
  assign rep_coeff_o = (valid_i && mcast_i) ? mcast_rep_i : '0;

endmodule

// File: source/xy_route_select.sv
// xy route selector, top level
// one input port of a 4x4 mesh router
// unicast xy decode and multicast mask decode in parallel,
// route locking per packet, multicast mask split per output
// fully combinational apart from the lock state

`timescale 1ns/100ps

`include "xy_route_consts.svh"

module xy_route_select (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  input  xy_route_pkg::xy_coord_t                      xy_id_i,
  input  xy_route_pkg::xy_flit_t                       flit_i,
  input  logic                                         valid_i,
  input  logic                                         ready_i,
  output xy_route_pkg::xy_flit_t [`XY_NUM_ROUTES-1:0] flit_o,
  output logic [`XY_NUM_ROUTES-1:0]                   route_sel_o,
  output logic [`XY_REP_W-1:0]                        rep_coeff_o
);

  import xy_route_pkg::*;

  xy_hdr_t                   hdr;
  xy_coord_t                 dst_coord;
  logic [`XY_MASK_W-1:0]     dst_mask;
  logic [`XY_NUM_ROUTES-1:0] ucast_route;
  logic [`XY_NUM_ROUTES-1:0] mcast_route;
  logic [`XY_REP_W-1:0]      mcast_rep;

  assign hdr = flit_i.hdr;

  // same destination word, two readings
  assign dst_coord = hdr.dst.pos.coord;
  assign dst_mask  = hdr.dst.mask;

  // unicast path
  xy_unicast_decoder u_ucast_dec (
    .dst_i   (dst_coord),
    .xy_id_i (xy_id_i),
    .route_o (ucast_route)
  );

  // multicast path
  mcast_port_select u_mcast_sel (
    .mask_i      (dst_mask),
    .xy_id_i     (xy_id_i),
    .route_o     (mcast_route),
    .rep_coeff_o (mcast_rep)
  );

  // per output flit copies
  mcast_mask_split u_mask_split (
    .flit_i  (flit_i),
    .xy_id_i (xy_id_i),
    .flit_o  (flit_o)
  );

  // route choice and packet lock
  route_lock_ctrl u_lock_ctrl (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .valid_i       (valid_i),
    .ready_i       (ready_i),
    .mcast_i       (hdr.mcast),
    .last_i        (hdr.last),
    .ucast_route_i (ucast_route),
    .mcast_route_i (mcast_route),
    .mcast_rep_i   (mcast_rep),
    .route_sel_o   (route_sel_o),
    .rep_coeff_o   (rep_coeff_o)
  );

endmodule

// File: tests/tb_xy_route_ref.svh
// reference model for the xy route selector testbench
// lcg random source, per node direction rule,
// expected route, replication count and per output flit

`ifndef TB_XY_ROUTE_REF_SVH
`define TB_XY_ROUTE_REF_SVH

logic [31:0] lcg_state;

// 32 bit lcg
// upper bits returned since the low bits cycle quickly
function automatic logic [15:0] lcg_next();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state[30:15];
endfunction

// output that leads towards node n under xy order
function automatic int node_port(input int n, input xy_coord_t own);
  int nx;
  int ny;
  int ox;
  int oy;
  nx = n / `XY_NUM_Y;
  ny = n % `XY_NUM_Y;
  ox = int'(own.x);
  oy = int'(own.y);
  if (nx > ox) return `XY_PORT_EAST;
  if (nx < ox) return `XY_PORT_WEST;
  if (ny > oy) return `XY_PORT_NORTH;
  if (ny < oy) return `XY_PORT_SOUTH;
  return `XY_PORT_EJECT;
endfunction

// live route and count of one flit
// no valid gating and no lock here
function automatic void ref_route(input xy_flit_t f, input xy_coord_t own,
                                  output logic [`XY_NUM_ROUTES-1:0] route,
                                  output logic [`XY_REP_W-1:0] rep);
  xy_coord_t d;
  route = '0;
  rep   = '0;
  if (f.hdr.mcast) begin
    // every marked node pulls in its output
    for (int n = 0; n < `XY_MASK_W; n++) begin
      if (f.hdr.dst.mask[n]) begin
        route[node_port(n, own)] = 1'b1;
      end
    end
    rep = `XY_REP_W'($countones(route));
  end else begin
    d = f.hdr.dst.pos.coord;
    route[node_port(int'(d.x) * `XY_NUM_Y + int'(d.y), own)] = 1'b1;
  end
endfunction

// expected flit copy on output p
function automatic xy_flit_t ref_split(input xy_flit_t f, input xy_coord_t own,
                                       input int p);
  xy_flit_t o;
  o = f;
  // eject keeps the whole mask
  if (f.hdr.mcast && p != `XY_PORT_EJECT) begin
    for (int n = 0; n < `XY_MASK_W; n++) begin
      o.hdr.dst.mask[n] = f.hdr.dst.mask[n] && (node_port(n, own) == p);
    end
  end
  return o;
endfunction

`endif

// File: tests/tb_xy_route_select.sv
// testbench for the xy route selector
// random unicast and multicast flits, multi-flit packets
// with gaps and back-pressure, every cycle compared
// against a reference model of routing, split and lock

`timescale 1ns/100ps

`include "xy_route_consts.svh"

module tb_xy_route_select;

  import xy_route_pkg::*;

  `include "tb_xy_route_ref.svh"

  // cycles a flit may wait for acceptance
  localparam int accept_limit = 50;

  logic                              clk = 1'b0;
  logic                              arst_n;
  xy_coord_t                         xy_id;
  xy_flit_t                          flit;
  logic                              valid;
  logic                              ready;
  xy_flit_t [`XY_NUM_ROUTES-1:0]     flit_out;
  logic [`XY_NUM_ROUTES-1:0]         route_sel;
  logic [`XY_REP_W-1:0]              rep_coeff;

  // lock model
  logic                              model_locked;
  logic [`XY_NUM_ROUTES-1:0]         model_route;

  int err_count;
  int tests_passed;
  int tests_failed;

  xy_route_select dut0 (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .xy_id_i     (xy_id),
    .flit_i      (flit),
    .valid_i     (valid),
    .ready_i     (ready),
    .flit_o      (flit_out),
    .route_sel_o (route_sel),
    .rep_coeff_o (rep_coeff)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // compare on the rising edge before the flops update
  // then step the lock model with the accepted flit
  always @(posedge clk) begin : compare_proc
    logic [`XY_NUM_ROUTES-1:0] live;
    logic [`XY_NUM_ROUTES-1:0] exp_route;
    logic [`XY_REP_W-1:0]      live_rep;
    logic [`XY_REP_W-1:0]      exp_rep;
    xy_flit_t                  exp_flit;
    ref_route(flit, xy_id, live, live_rep);
    if (!valid) begin
      live = '0;
    end
    // route shown in the cycle ending here
    exp_route = model_locked ? model_route : live;
    exp_rep   = (valid && flit.hdr.mcast) ? live_rep : '0;
    assert (route_sel === exp_route) else begin
      $display("mismatch at %0t: route_sel_o %b, expected %b",
               $time, route_sel, exp_route);
      err_count++;
    end
    assert (rep_coeff === exp_rep) else begin
      $display("mismatch at %0t: rep_coeff_o %0d, expected %0d",
               $time, rep_coeff, exp_rep);
      err_count++;
    end
    for (int p = 0; p < `XY_NUM_ROUTES; p++) begin
      exp_flit = ref_split(flit, xy_id, p);
      assert (flit_out[p] === exp_flit) else begin
        $display("mismatch at %0t: flit_o[%0d] %h, expected %h",
                 $time, p, flit_out[p], exp_flit);
        err_count++;
      end
    end
    if (!arst_n) begin
      model_locked = 1'b0;
      model_route  = '0;
    end else if (valid && ready) begin
      // a non-last flit holds this cycle's route
      if (!flit.hdr.last) begin
        model_route = exp_route;
      end
      model_locked = !flit.hdr.last;
    end
  end

  function automatic xy_coord_t rand_coord();
    logic [15:0] r;
    r = lcg_next();
    return r[2*`XY_COORD_W-1:0];
  endfunction

  // unicast flits read random upper bits as unused
  function automatic xy_flit_t rand_flit(input logic mcast, input logic last);
    xy_flit_t f;
    f.payload      = {lcg_next(), lcg_next()};
    f.hdr.mcast    = mcast;
    f.hdr.last     = last;
    f.hdr.dst.mask = lcg_next();
    return f;
  endfunction

  // present a flit, ready rises after stall cycles
  task automatic send_flit(input xy_coord_t own, input xy_flit_t f, input int stall);
    int waited;
    @(negedge clk);
    xy_id  = own;
    flit   = f;
    valid  = 1'b1;
    ready  = (stall == 0);
    waited = 0;
    while (1) begin
      @(posedge clk);
      if (valid && ready) begin
        break;
      end
      waited++;
      if (waited > accept_limit) begin
        $display("timeout: flit was not accepted within %0d cycles", accept_limit);
        $display("TESTBENCH FAILED");
        $finish;
      end
      @(negedge clk);
      ready = (waited >= stall);
    end
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      valid = 1'b0;
      ready = 1'b0;
    end
  endtask

  task automatic finish_test(input string name);
    if (err_count == 0) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, err_count);
    end
    err_count = 0;
  endtask

  initial begin
    xy_coord_t own;
    xy_flit_t  f;
    lcg_state    = 32'd54431;
    arst_n       = 1'b0;
    xy_id        = '0;
    flit         = '0;
    valid        = 1'b0;
    ready        = 1'b0;
    model_locked = 1'b0;
    model_route  = '0;
    err_count    = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (3) @(negedge clk);
    arst_n = 1'b1;

    idle(3);
    finish_test("reset");

    repeat (40) send_flit(rand_coord(), rand_flit(1'b0, 1'b1), 0);
    idle(1);
    finish_test("unicast xy");

    repeat (40) send_flit(rand_coord(), rand_flit(1'b1, 1'b1), 0);
    idle(1);
    finish_test("multicast select");

    // sparser masks plus one full mask
    repeat (30) begin
      f = rand_flit(1'b1, 1'b1);
      f.hdr.dst.mask = f.hdr.dst.mask & lcg_next();
      send_flit(rand_coord(), f, 0);
    end
    f = rand_flit(1'b1, 1'b1);
    f.hdr.dst.mask = '1;
    send_flit(rand_coord(), f, 0);
    idle(1);
    finish_test("mask split");

    // unicast head, then multicast head
    own = rand_coord();
    for (int k = 0; k < 2; k++) begin
      send_flit(own, rand_flit(k == 1, 1'b0), 0);
      idle(2);
      send_flit(own, rand_flit(1'b0, 1'b0), 0);
      idle(1);
      send_flit(own, rand_flit(1'b1, 1'b0), 0);
      send_flit(own, rand_flit(1'b0, 1'b1), 0);
      send_flit(own, rand_flit(1'b0, 1'b1), 0);
      idle(1);
    end
    finish_test("route lock");

    own = rand_coord();
    send_flit(own, rand_flit(1'b0, 1'b0), 3);
    idle(2);
    send_flit(own, rand_flit(1'b1, 1'b0), 2);
    send_flit(own, rand_flit(1'b0, 1'b1), 4);
    send_flit(own, rand_flit(1'b1, 1'b1), 2);
    idle(2);
    finish_test("back-pressure");

    $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: xy_route_select.f
+incdir+source
+incdir+tests
source/xy_route_pkg.sv
source/xy_unicast_decoder.sv
source/mcast_port_select.sv
source/mcast_mask_split.sv
source/route_lock_ctrl.sv
source/xy_route_select.sv
tests/tb_xy_route_select.sv

// File: Bender.yml
package:
  name: xy_route_select

sources:
  - include_dirs:
      - source
    files:
      - source/xy_route_pkg.sv
      - source/xy_unicast_decoder.sv
      - source/mcast_port_select.sv
      - source/mcast_mask_split.sv
      - source/route_lock_ctrl.sv
      - source/xy_route_select.sv
  - target: test
    include_dirs:
      - source
      - tests
    files:
      - tests/tb_xy_route_select.sv
